//--- id_stage.f
source/id_pkg.sv
source/id_decoder.sv
source/id_register_file.sv
source/id_operand_select.sv
source/id_multicycle_tracker.sv
source/id_stage.sv
dv/id_stage_tb.sv

//--- run_verilator.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module id_stage_tb -f id_stage.f -o id_stage_sim
output=$(./obj_dir/id_stage_sim)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

//--- dv/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();

	localparam int N_WRITE = 40;
	localparam int N_ALU = 60;
	localparam int N_LOAD = 24;
	localparam int N_STORE = 20;
	localparam int N_BRANCH = 30;
	localparam int N_JUMP = 10;
	localparam int MAX_LAT = 4;
	localparam int NUM_INSTR = N_WRITE * 2 + N_ALU + N_LOAD * 2 + N_STORE + N_BRANCH
		+ N_JUMP + 8;
	localparam int WATCHDOG_NS = NUM_INSTR * 20 * 10 + 100;

	typedef struct packed {
		alu_op_e     op;
		logic [31:0] a;
		logic [31:0] b;
		data_type_e  dtype;
		logic        sext;
		logic        we;
		logic        mem;
		logic        bad;
		logic        illegal;
	} expect_t;

	logic        clk_i;
	logic        rst_ni;
	logic        instr_valid_i;
	logic        instr_new_i;
	logic [31:0] instr_rdata_i;
	logic [31:0] pc_id_i;
	logic        branch_decision_i;
	logic        ex_valid_i;
	logic        lsu_valid_i;
	logic        lsu_load_err_i;
	logic        lsu_addr_incr_req_i;
	logic [31:0] lsu_addr_last_i;
	logic [31:0] regfile_wdata_ex_i;
	logic [31:0] regfile_wdata_lsu_i;
	alu_op_e     alu_operator_ex_o;
	logic [31:0] alu_operand_a_ex_o;
	logic [31:0] alu_operand_b_ex_o;
	logic        data_req_ex_o;
	logic        data_we_ex_o;
	data_type_e  data_type_ex_o;
	logic        data_sign_ext_ex_o;
	logic [31:0] data_wdata_ex_o;
	logic        illegal_insn_o;
	logic        id_ready_o;
	logic        jump_set_o;
	logic        branch_set_o;
	logic        instr_ret_o;

	// architectural copy of the register file where x0 stays zero.
	logic [31:0] shadow [0:31];
	logic [31:0] pc;
	logic        check_en;
	int          errors;
	expect_t     exp_now;

	id_stage UUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// **************************************************
	// reporting and reference model
	// **************************************************

	task automatic word_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		errors++;
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
	endtask

	task automatic bit_mismatch(input string name, input logic exp, input logic got);
		errors++;
		$display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, got);
	endtask

	function automatic logic [31:0] make_word(input logic [6:0] hi, input logic [4:0] f_rs2,
		input logic [4:0] f_rs1, input logic [2:0] f3, input logic [4:0] f_rd,
		input logic [6:0] opc);
		return {hi, f_rs2, f_rs1, f3, f_rd, opc};
	endfunction

	function automatic expect_t ref_decode(input logic [31:0] w);
		expect_t     e;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] rs2v;
		f3 = w[14:12];
		f7 = w[31:25];
		rs2v = shadow[w[24:20]];
		e.op = ALU_ADD;
		e.a = shadow[w[19:15]];
		e.b = {{20{w[31]}}, w[31:20]};
		e.dtype = DATA_WORD;
		e.sext = 1'b1;
		e.we = 1'b0;
		e.mem = 1'b0;
		e.bad = 1'b0;
		case (w[6:0])
			OPCODE_LUI: begin
				e.a = 32'd0;
				e.b = {w[31:12], 12'h000};
			end
			OPCODE_AUIPC: begin
				e.a = pc_id_i;
				e.b = {w[31:12], 12'h000};
			end
			OPCODE_JAL, OPCODE_JALR: begin
				// link address.
				e.a = pc_id_i;
				e.b = 32'd4;
				e.bad = (w[6:0] == OPCODE_JALR) && (f3 != 3'b000);
			end
			OPCODE_OP_IMM: begin
				case (f3)
					3'd0: e.op = ALU_ADD;
					3'd2: e.op = ALU_SLT;
					3'd3: e.op = ALU_SLTU;
					3'd4: e.op = ALU_XOR;
					3'd6: e.op = ALU_OR;
					3'd7: e.op = ALU_AND;
					3'd1: begin
						e.op = ALU_SLL;
						e.bad = (f7 != 7'h00);
					end
					default: begin
						e.op = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
						e.bad = (f7 != 7'h00) && (f7 != 7'h20);
					end
				endcase
			end
			OPCODE_OP: begin
				e.b = rs2v;
				if (f7 == 7'h00) begin
					case (f3)
						3'd0: e.op = ALU_ADD;
						3'd1: e.op = ALU_SLL;
						3'd2: e.op = ALU_SLT;
						3'd3: e.op = ALU_SLTU;
						3'd4: e.op = ALU_XOR;
						3'd5: e.op = ALU_SRL;
						3'd6: e.op = ALU_OR;
						default: e.op = ALU_AND;
					endcase
				end else if (f7 == 7'h20 && f3 == 3'd0) begin
					e.op = ALU_SUB;
				end else if (f7 == 7'h20 && f3 == 3'd5) begin
					e.op = ALU_SRA;
				end else begin
					e.bad = 1'b1;
				end
			end
			OPCODE_BRANCH: begin
				e.b = rs2v;
				case (f3)
					3'd0: e.op = ALU_EQ;
					3'd1: e.op = ALU_NE;
					3'd4: e.op = ALU_LT;
					3'd5: e.op = ALU_GE;
					3'd6: e.op = ALU_LTU;
					3'd7: e.op = ALU_GEU;
					default: e.bad = 1'b1;
				endcase
			end
			OPCODE_LOAD: begin
				e.mem = 1'b1;
				// lbu and lhu zero-extend.
				e.sext = (f3 != 3'd4) && (f3 != 3'd5);
				case (f3)
					3'd0, 3'd4: e.dtype = DATA_BYTE;
					3'd1, 3'd5: e.dtype = DATA_HALF;
					3'd2: e.dtype = DATA_WORD;
					default: e.bad = 1'b1;
				endcase
			end
			OPCODE_STORE: begin
				e.mem = 1'b1;
				e.we = 1'b1;
				e.b = {{20{w[31]}}, w[31:25], w[11:7]};
				case (f3)
					3'd0: e.dtype = DATA_BYTE;
					3'd1: e.dtype = DATA_HALF;
					3'd2: e.dtype = DATA_WORD;
					default: e.bad = 1'b1;
				endcase
			end
			default: e.bad = 1'b1;
		endcase
		if (e.bad) begin
			e.we = 1'b0;
		end
		// second access of a misaligned transfer.
		if (lsu_addr_incr_req_i) begin
			e.a = lsu_addr_last_i;
			e.b = 32'd4;
		end
		e.illegal = instr_valid_i & e.bad;
		return e;
	endfunction

	always @(negedge clk_i) begin
		if (check_en) begin
			exp_now = ref_decode(instr_rdata_i);
			if (illegal_insn_o !== exp_now.illegal)
				bit_mismatch("illegal_insn_o", exp_now.illegal, illegal_insn_o);
			if (data_we_ex_o !== exp_now.we)
				bit_mismatch("data_we_ex_o", exp_now.we, data_we_ex_o);
			if (data_wdata_ex_o !== shadow[instr_rdata_i[24:20]])
				word_mismatch("data_wdata_ex_o", shadow[instr_rdata_i[24:20]], data_wdata_ex_o);
			if (lsu_addr_incr_req_i || !exp_now.bad) begin
				if (alu_operand_a_ex_o !== exp_now.a)
					word_mismatch("alu_operand_a_ex_o", exp_now.a, alu_operand_a_ex_o);
				if (alu_operand_b_ex_o !== exp_now.b)
					word_mismatch("alu_operand_b_ex_o", exp_now.b, alu_operand_b_ex_o);
			end
			if (!lsu_addr_incr_req_i && !exp_now.bad) begin
				if (alu_operator_ex_o !== exp_now.op)
					word_mismatch("alu_operator_ex_o", {27'd0, exp_now.op},
						{27'd0, alu_operator_ex_o});
			end
			if (!exp_now.bad && exp_now.mem) begin
				if (data_type_ex_o !== exp_now.dtype)
					word_mismatch("data_type_ex_o", {30'd0, exp_now.dtype},
						{30'd0, data_type_ex_o});
				if (data_sign_ext_ex_o !== exp_now.sext)
					bit_mismatch("data_sign_ext_ex_o", exp_now.sext, data_sign_ext_ex_o);
			end
		end
	end

	// **************************************************
	// instruction sequencing
	// **************************************************

	task automatic issue_single(input logic [31:0] w, input logic [31:0] ex_data,
		input logic taken);
		expect_t e;
		@(posedge clk_i);
		instr_new_i <= 1'b1;
		instr_rdata_i <= w;
		pc_id_i <= pc;
		regfile_wdata_ex_i <= ex_data;
		branch_decision_i <= taken;
		@(negedge clk_i);
		if (instr_ret_o !== 1'b1) bit_mismatch("instr_ret_o", 1'b1, instr_ret_o);
		if (id_ready_o !== 1'b1) bit_mismatch("id_ready_o", 1'b1, id_ready_o);
		if (data_req_ex_o !== 1'b0) bit_mismatch("data_req_ex_o", 1'b0, data_req_ex_o);
		if (jump_set_o !== 1'b0) bit_mismatch("jump_set_o", 1'b0, jump_set_o);
		e = ref_decode(w);
		@(posedge clk_i);
		instr_new_i <= 1'b0;
		branch_decision_i <= 1'b0;
		if (!e.bad && !e.mem && w[6:0] != OPCODE_BRANCH && w[11:7] != 5'd0)
			shadow[w[11:7]] = ex_data;
		pc = pc + 32'd4;
		@(negedge clk_i);
		if (instr_ret_o !== 1'b0) bit_mismatch("instr_ret_o", 1'b0, instr_ret_o);
		if (branch_set_o !== 1'b0) bit_mismatch("branch_set_o", 1'b0, branch_set_o);
	endtask

	task automatic issue_multi(input logic [31:0] w, input logic taken, input int lat,
		input logic err, input logic [31:0] data);
		logic is_load;
		logic is_mem;
		logic is_jump;
		logic is_branch;
		logic exp_bs;
		int   cyc;
		is_load = (w[6:0] == OPCODE_LOAD);
		is_mem = is_load || (w[6:0] == OPCODE_STORE);
		is_jump = (w[6:0] == OPCODE_JAL) || (w[6:0] == OPCODE_JALR);
		is_branch = (w[6:0] == OPCODE_BRANCH);
		@(posedge clk_i);
		instr_new_i <= 1'b1;
		instr_rdata_i <= w;
		pc_id_i <= pc;
		branch_decision_i <= taken;
		// the unused write-back source carries other data.
		regfile_wdata_ex_i <= is_load ? ~data : data;
		regfile_wdata_lsu_i <= is_load ? data : ~data;
		lsu_load_err_i <= err;
		@(negedge clk_i);
		if (id_ready_o !== 1'b0) bit_mismatch("id_ready_o", 1'b0, id_ready_o);
		if (instr_ret_o !== 1'b0) bit_mismatch("instr_ret_o", 1'b0, instr_ret_o);
		if (data_req_ex_o !== is_mem) bit_mismatch("data_req_ex_o", is_mem, data_req_ex_o);
		if (jump_set_o !== is_jump) bit_mismatch("jump_set_o", is_jump, jump_set_o);
		@(posedge clk_i);
		instr_new_i <= 1'b0;
		branch_decision_i <= 1'b0;
		// the link value lands on the first edge.
		if (is_jump && w[11:7] != 5'd0)
			shadow[w[11:7]] = data;
		cyc = 1;
		while (cyc <= lat) begin
			exp_bs = is_branch && (cyc == 1);
			@(negedge clk_i);
			if (id_ready_o !== 1'b0) bit_mismatch("id_ready_o", 1'b0, id_ready_o);
			if (instr_ret_o !== 1'b0) bit_mismatch("instr_ret_o", 1'b0, instr_ret_o);
			if (data_req_ex_o !== is_mem) bit_mismatch("data_req_ex_o", is_mem, data_req_ex_o);
			if (jump_set_o !== 1'b0) bit_mismatch("jump_set_o", 1'b0, jump_set_o);
			if (branch_set_o !== exp_bs) bit_mismatch("branch_set_o", exp_bs, branch_set_o);
			@(posedge clk_i);
			cyc++;
		end
		if (is_mem)
			lsu_valid_i <= 1'b1;
		else
			ex_valid_i <= 1'b1;
		exp_bs = is_branch && (cyc == 1);
		@(negedge clk_i);
		if (instr_ret_o !== 1'b1) bit_mismatch("instr_ret_o", 1'b1, instr_ret_o);
		if (id_ready_o !== 1'b1) bit_mismatch("id_ready_o", 1'b1, id_ready_o);
		if (data_req_ex_o !== is_mem) bit_mismatch("data_req_ex_o", is_mem, data_req_ex_o);
		if (branch_set_o !== exp_bs) bit_mismatch("branch_set_o", exp_bs, branch_set_o);
		@(posedge clk_i);
		lsu_valid_i <= 1'b0;
		ex_valid_i <= 1'b0;
		lsu_load_err_i <= 1'b0;
		if (is_load && !err && w[11:7] != 5'd0)
			shadow[w[11:7]] = data;
		pc = pc + 32'd4;
		@(negedge clk_i);
		if (instr_ret_o !== 1'b0) bit_mismatch("instr_ret_o", 1'b0, instr_ret_o);
		if (data_req_ex_o !== 1'b0) bit_mismatch("data_req_ex_o", 1'b0, data_req_ex_o);
		if (id_ready_o !== 1'b1) bit_mismatch("id_ready_o", 1'b1, id_ready_o);
		if (branch_set_o !== 1'b0) bit_mismatch("branch_set_o", 1'b0, branch_set_o);
	endtask

	task automatic check_addr_override(input logic [31:0] last);
		@(posedge clk_i);
		lsu_addr_incr_req_i <= 1'b1;
		lsu_addr_last_i <= last;
		@(negedge clk_i);
		if (alu_operand_a_ex_o !== last)
			word_mismatch("alu_operand_a_ex_o", last, alu_operand_a_ex_o);
		if (alu_operand_b_ex_o !== 32'd4)
			word_mismatch("alu_operand_b_ex_o", 32'd4, alu_operand_b_ex_o);
		@(posedge clk_i);
		lsu_addr_incr_req_i <= 1'b0;
	endtask

	// **************************************************
	// main sequence
	// **************************************************

	initial begin
		logic [31:0] r;
		logic [31:0] w;
		logic [6:0]  f7;
		logic [2:0]  f3;
		int          lat;
		int          kind;
		void'($urandom(32));
		rst_ni = 1'b0;
		instr_valid_i = 1'b1;
		instr_new_i = 1'b0;
		instr_rdata_i = 32'h0000_0013;
		pc_id_i = 32'd0;
		branch_decision_i = 1'b0;
		ex_valid_i = 1'b0;
		lsu_valid_i = 1'b0;
		lsu_load_err_i = 1'b0;
		lsu_addr_incr_req_i = 1'b0;
		lsu_addr_last_i = 32'd0;
		regfile_wdata_ex_i = 32'd0;
		regfile_wdata_lsu_i = 32'd0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = 32'd0;
		end
		errors = 0;
		check_en = 1'b0;
		pc = 32'h0000_1000;
		repeat (4) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(posedge clk_i);
		check_en = 1'b1;

		// each addi/lui write is read back on both ports.
		for (int i = 0; i < N_WRITE; i++) begin
			r = $urandom;
			if (r[0])
				w = make_word(r[31:25], r[24:20], r[19:15], 3'd0, r[11:7], OPCODE_OP_IMM);
			else
				w = {r[31:12], r[11:7], OPCODE_LUI};
			issue_single(w, $urandom, 1'b0);
			issue_single(make_word(7'h00, r[11:7], r[11:7], 3'd0, 5'd0, OPCODE_OP), 32'd0, 1'b0);
		end

		r = $urandom;
		pc = {r[31:2], 2'b00};
		for (int i = 0; i < N_ALU; i++) begin
			r = $urandom;
			kind = $urandom_range(3, 0);
			f3 = r[14:12];
			if (kind == 0) begin
				f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[31]) ? 7'h20 : 7'h00;
				issue_single(make_word(f7, r[24:20], r[19:15], f3, r[11:7], OPCODE_OP),
					$urandom, 1'b0);
			end else if (kind == 1) begin
				f7 = r[31:25];
				if (f3 == 3'd1)
					f7 = 7'h00;
				else if (f3 == 3'd5)
					f7 = r[0] ? 7'h20 : 7'h00;
				issue_single(make_word(f7, r[24:20], r[19:15], f3, r[11:7], OPCODE_OP_IMM),
					$urandom, 1'b0);
			end else if (kind == 2) begin
				issue_single({r[31:12], r[11:7], OPCODE_AUIPC}, $urandom, 1'b0);
			end else begin
				lat = $urandom_range(MAX_LAT, 0);
				issue_multi({r[31:12], r[11:7], OPCODE_JAL}, 1'b0, lat, 1'b0, $urandom);
			end
		end

		// loads where some end in an error and rd is read back.
		for (int i = 0; i < N_LOAD; i++) begin
			r = $urandom;
			f3 = r[14:12];
			if (f3 == 3'd3 || f3 > 3'd5)
				f3 = 3'd2;
			lat = $urandom_range(MAX_LAT, 0);
			w = make_word(r[31:25], r[24:20], r[19:15], f3, r[11:7], OPCODE_LOAD);
			issue_multi(w, 1'b0, lat, (r[1:0] == 2'b00), $urandom);
			issue_single(make_word(7'h00, 5'd0, r[11:7], 3'd0, 5'd0, OPCODE_OP_IMM),
				32'd0, 1'b0);
		end

		for (int i = 0; i < N_STORE; i++) begin
			r = $urandom;
			f3 = (r[14:12] > 3'd2) ? 3'd2 : r[14:12];
			lat = $urandom_range(MAX_LAT, 0);
			w = make_word(r[31:25], r[24:20], r[19:15], f3, r[11:7], OPCODE_STORE);
			issue_multi(w, 1'b0, lat, 1'b0, 32'd0);
		end

		for (int i = 0; i < N_BRANCH; i++) begin
			r = $urandom;
			f3 = r[14:12];
			if (f3 == 3'd2 || f3 == 3'd3)
				f3 = 3'd0;
			lat = $urandom_range(MAX_LAT, 0);
			w = make_word(r[31:25], r[24:20], r[19:15], f3, r[11:7], OPCODE_BRANCH);
			if (r[0])
				issue_multi(w, 1'b1, lat, 1'b0, 32'd0);
			else
				issue_single(w, 32'd0, 1'b0);
		end

		for (int i = 0; i < N_JUMP; i++) begin
			r = $urandom;
			lat = $urandom_range(MAX_LAT, 0);
			if (r[0])
				w = {r[31:12], r[11:7], OPCODE_JAL};
			else
				w = make_word(r[31:25], r[24:20], r[19:15], 3'd0, r[11:7], OPCODE_JALR);
			issue_multi(w, 1'b0, lat, 1'b0, $urandom);
		end

		// unknown opcode with and without a valid instruction.
		r = $urandom;
		issue_single({r[31:7], 7'h0b}, 32'd0, 1'b0);
		if (illegal_insn_o !== 1'b1) bit_mismatch("illegal_insn_o", 1'b1, illegal_insn_o);
		@(posedge clk_i);
		instr_valid_i <= 1'b0;
		@(negedge clk_i);
		if (illegal_insn_o !== 1'b0) bit_mismatch("illegal_insn_o", 1'b0, illegal_insn_o);
		@(posedge clk_i);
		instr_valid_i <= 1'b1;
		check_addr_override($urandom);
		// a register operand b must give way to the increment too.
		issue_single(make_word(7'h00, r[24:20], r[19:15], 3'd0, 5'd9, OPCODE_OP),
			$urandom, 1'b0);
		check_addr_override($urandom);

		repeat (2) @(posedge clk_i);
		$display("Checks complete with %0d errors", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the instruction sequence completed");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  logic            instr_valid_i,
	input  logic            instr_new_i,
	input  logic [XLEN-1:0] instr_rdata_i,
	input  logic [XLEN-1:0] pc_id_i,
	input  logic            branch_decision_i,
	input  logic            ex_valid_i,
	input  logic            lsu_valid_i,
	input  logic            lsu_load_err_i,
	input  logic            lsu_addr_incr_req_i,
	input  logic [XLEN-1:0] lsu_addr_last_i,
	input  logic [XLEN-1:0] regfile_wdata_ex_i,
	input  logic [XLEN-1:0] regfile_wdata_lsu_i,
	output alu_op_e         alu_operator_ex_o,
	output logic [XLEN-1:0] alu_operand_a_ex_o,
	output logic [XLEN-1:0] alu_operand_b_ex_o,
	output logic            data_req_ex_o,
	output logic            data_we_ex_o,
	output data_type_e      data_type_ex_o,
	output logic            data_sign_ext_ex_o,
	output logic [XLEN-1:0] data_wdata_ex_o,
	output logic            illegal_insn_o,
	output logic            id_ready_o,
	output logic            jump_set_o,
	output logic            branch_set_o,
	output logic            instr_ret_o
);
	logic                  illegal_dec;
	op_a_sel_e             op_a_sel;
	op_b_sel_e             op_b_sel;
	imm_b_sel_e            imm_b_sel;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       imm_s;
	logic [XLEN-1:0]       imm_b;
	logic [XLEN-1:0]       imm_u;
	logic [XLEN-1:0]       imm_j;
	logic [REG_ADDR_W-1:0] raddr_a;
	logic [REG_ADDR_W-1:0] raddr_b;
	logic [REG_ADDR_W-1:0] waddr;
	logic                  rf_we_dec;
	rf_wd_sel_e            rf_wd_sel;
	logic                  data_req_dec;
	logic                  branch_dec;
	logic                  jump_dec;
	logic [XLEN-1:0]       rdata_a;
	logic [XLEN-1:0]       rdata_b;
	logic [XLEN-1:0]       rf_wdata;
	logic                  rf_we;
	logic                  executing;
	logic                  stall;

	// **************************************************
	// decode and register file
	// **************************************************

	id_decoder decoder_i (
		.instr_rdata_i  (instr_rdata_i),
		.illegal_insn_o (illegal_dec),
		.alu_operator_o (alu_operator_ex_o),
		.op_a_sel_o     (op_a_sel),
		.op_b_sel_o     (op_b_sel),
		.imm_b_sel_o    (imm_b_sel),
		.imm_i_o        (imm_i),
		.imm_s_o        (imm_s),
		.imm_b_o        (imm_b),
		.imm_u_o        (imm_u),
		.imm_j_o        (imm_j),
		.raddr_a_o      (raddr_a),
		.raddr_b_o      (raddr_b),
		.waddr_o        (waddr),
		.rf_we_o        (rf_we_dec),
		.rf_wd_sel_o    (rf_wd_sel),
		.data_req_o     (data_req_dec),
		.data_we_o      (data_we_ex_o),
		.data_type_o    (data_type_ex_o),
		.data_sign_ext_o(data_sign_ext_ex_o),
		.branch_o       (branch_dec),
		.jump_o         (jump_dec)
	);

	assign rf_wdata = (rf_wd_sel == RF_WD_LSU) ? regfile_wdata_lsu_i : regfile_wdata_ex_i;

	id_register_file registers_i (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.raddr_a_i(raddr_a),
		.raddr_b_i(raddr_b),
		.waddr_i  (waddr),
		.wdata_i  (rf_wdata),
		.we_i     (rf_we),
		.rdata_a_o(rdata_a),
		.rdata_b_o(rdata_b)
	);

	id_operand_select operand_select_i (
		.op_a_sel_i         (op_a_sel),
		.op_b_sel_i         (op_b_sel),
		.imm_b_sel_i        (imm_b_sel),
		.imm_i_i            (imm_i),
		.imm_s_i            (imm_s),
		.imm_b_i            (imm_b),
		.imm_u_i            (imm_u),
		.imm_j_i            (imm_j),
		.rdata_a_i          (rdata_a),
		.rdata_b_i          (rdata_b),
		.pc_id_i            (pc_id_i),
		.lsu_addr_incr_req_i(lsu_addr_incr_req_i),
		.lsu_addr_last_i    (lsu_addr_last_i),
		.operand_a_o        (alu_operand_a_ex_o),
		.operand_b_o        (alu_operand_b_ex_o)
	);

	// **************************************************
	// multicycle tracking
	// **************************************************

	id_multicycle_tracker tracker_i (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.instr_new_i      (instr_new_i),
		.data_req_i       (data_req_dec),
		.branch_i         (branch_dec),
		.jump_i           (jump_dec),
		.branch_decision_i(branch_decision_i),
		.ex_valid_i       (ex_valid_i),
		.lsu_valid_i      (lsu_valid_i),
		.lsu_load_err_i   (lsu_load_err_i),
		.rf_we_dec_i      (rf_we_dec),
		.executing_o      (executing),
		.rf_we_o          (rf_we),
		.stall_o          (stall),
		.branch_set_o     (branch_set_o),
		.instr_ret_o      (instr_ret_o)
	);

	assign data_req_ex_o = executing & data_req_dec;
	assign data_wdata_ex_o = rdata_b;
	assign illegal_insn_o = instr_valid_i & illegal_dec;
	assign id_ready_o = ~stall;
	assign jump_set_o = instr_new_i & jump_dec;

endmodule

`default_nettype wire

//--- source/id_multicycle_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module id_multicycle_tracker (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic instr_new_i,
	input  logic data_req_i,
	input  logic branch_i,
	input  logic jump_i,
	input  logic branch_decision_i,
	input  logic ex_valid_i,
	input  logic lsu_valid_i,
	input  logic lsu_load_err_i,
	input  logic rf_we_dec_i,
	output logic executing_o,
	output logic rf_we_o,
	output logic stall_o,
	output logic branch_set_o,
	output logic instr_ret_o
);
	typedef enum logic {
		IDLE,
		WAIT_MULTICYCLE
	} state_e;

	state_e state_q;
	state_e state_d;
	logic   done_q;
	logic   done_d;
	logic   branch_set_d;
	logic   multicycle;
	logic   complete;
	logic   rf_we_wb;

	assign multicycle = data_req_i | branch_i | jump_i;

	// done keeps a finished instruction from issuing again while it is still held.
	assign executing_o = instr_new_i | (multicycle & ~done_q);

	// data accesses finish on the lsu, everything else on ex.
	assign complete = data_req_i ? lsu_valid_i : ex_valid_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
			done_q <= 1'b0;
			branch_set_o <= 1'b0;
		end else begin
			state_q <= state_d;
			done_q <= done_d;
			branch_set_o <= branch_set_d;
		end
	end

	always_comb begin
		state_d = state_q;
		done_d = done_q;
		branch_set_d = 1'b0;
		rf_we_wb = 1'b0;
		stall_o = 1'b0;
		instr_ret_o = 1'b0;

		unique case (state_q)
			IDLE: begin
				if (instr_new_i) begin
					if (data_req_i || jump_i || (branch_i && branch_decision_i)) begin
						state_d = WAIT_MULTICYCLE;
						stall_o = 1'b1;
						done_d = 1'b0;
						branch_set_d = branch_i;
					end else begin
						// a not-taken branch is finished here.
						done_d = branch_i;
						instr_ret_o = 1'b1;
					end
				end
			end
			WAIT_MULTICYCLE: begin
				if (complete) begin
					state_d = IDLE;
					done_d = 1'b1;
					rf_we_wb = rf_we_dec_i & ~lsu_load_err_i;
					instr_ret_o = 1'b1;
				end else begin
					stall_o = 1'b1;
				end
			end
		endcase
	end

	// loads write only on completion.
	assign rf_we_o = executing_o & (data_req_i ? rf_we_wb : rf_we_dec_i);

endmodule

`default_nettype wire

//--- source/id_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_select import id_pkg::*; (
	input  op_a_sel_e       op_a_sel_i,
	input  op_b_sel_e       op_b_sel_i,
	input  imm_b_sel_e      imm_b_sel_i,
	input  logic [XLEN-1:0] imm_i_i,
	input  logic [XLEN-1:0] imm_s_i,
	input  logic [XLEN-1:0] imm_b_i,
	input  logic [XLEN-1:0] imm_u_i,
	input  logic [XLEN-1:0] imm_j_i,
	input  logic [XLEN-1:0] rdata_a_i,
	input  logic [XLEN-1:0] rdata_b_i,
	input  logic [XLEN-1:0] pc_id_i,
	input  logic            lsu_addr_incr_req_i,
	input  logic [XLEN-1:0] lsu_addr_last_i,
	output logic [XLEN-1:0] operand_a_o,
	output logic [XLEN-1:0] operand_b_o
);
	op_a_sel_e       op_a_sel;
	op_b_sel_e       op_b_sel;
	imm_b_sel_e      imm_b_sel;
	logic [XLEN-1:0] imm_b;

	// second half of a misaligned access, last address + 4.
	assign op_a_sel = lsu_addr_incr_req_i ? OP_A_FWD : op_a_sel_i;
	assign op_b_sel = lsu_addr_incr_req_i ? OP_B_IMM : op_b_sel_i;
	assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_i;

	always_comb begin
		unique case (op_a_sel)
			OP_A_REG_A: operand_a_o = rdata_a_i;
			OP_A_FWD: operand_a_o = lsu_addr_last_i;
			OP_A_CURRPC: operand_a_o = pc_id_i;
			OP_A_IMM: operand_a_o = '0;
		endcase
	end

	always_comb begin
		unique case (imm_b_sel)
			IMM_B_I: imm_b = imm_i_i;
			IMM_B_S: imm_b = imm_s_i;
			IMM_B_B: imm_b = imm_b_i;
			IMM_B_U: imm_b = imm_u_i;
			IMM_B_J: imm_b = imm_j_i;
			IMM_B_INCR_PC: imm_b = PC_INCR;
			IMM_B_INCR_ADDR: imm_b = ADDR_INCR;
			default: imm_b = '0;
		endcase
	end

	assign operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rdata_b_i;

endmodule

`default_nettype wire

//--- source/id_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module id_register_file import id_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic [REG_ADDR_W-1:0] raddr_a_i,
	input  logic [REG_ADDR_W-1:0] raddr_b_i,
	input  logic [REG_ADDR_W-1:0] waddr_i,
	input  logic [XLEN-1:0]       wdata_i,
	input  logic                  we_i,
	output logic [XLEN-1:0]       rdata_a_o,
	output logic [XLEN-1:0]       rdata_b_o
);
	// x0 has no storage.
	logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- source/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
	input  logic [XLEN-1:0]       instr_rdata_i,
	output logic                  illegal_insn_o,
	output alu_op_e               alu_operator_o,
	output op_a_sel_e             op_a_sel_o,
	output op_b_sel_e             op_b_sel_o,
	output imm_b_sel_e            imm_b_sel_o,
	output logic [XLEN-1:0]       imm_i_o,
	output logic [XLEN-1:0]       imm_s_o,
	output logic [XLEN-1:0]       imm_b_o,
	output logic [XLEN-1:0]       imm_u_o,
	output logic [XLEN-1:0]       imm_j_o,
	output logic [REG_ADDR_W-1:0] raddr_a_o,
	output logic [REG_ADDR_W-1:0] raddr_b_o,
	output logic [REG_ADDR_W-1:0] waddr_o,
	output logic                  rf_we_o,
	output rf_wd_sel_e            rf_wd_sel_o,
	output logic                  data_req_o,
	output logic                  data_we_o,
	output data_type_e            data_type_o,
	output logic                  data_sign_ext_o,
	output logic                  branch_o,
	output logic                  jump_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       illegal;
	logic       rf_we;
	logic       data_req;
	logic       data_we;
	logic       branch;
	logic       jump;

	assign opcode = instr_rdata_i[6:0];
	assign funct3 = instr_rdata_i[14:12];
	assign funct7 = instr_rdata_i[31:25];

	assign raddr_a_o = instr_rdata_i[19:15];
	assign raddr_b_o = instr_rdata_i[24:20];
	assign waddr_o = instr_rdata_i[11:7];

	// sign-extended immediates, bit 31 is always the sign.
	assign imm_i_o = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
	assign imm_s_o = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
	assign imm_b_o = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
		instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
	assign imm_u_o = {instr_rdata_i[31:12], 12'h000};
	assign imm_j_o = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
		instr_rdata_i[30:21], 1'b0};

	// lbu/lhu carry funct3[2], loads and stores share the rule.
	assign data_sign_ext_o = ~funct3[2];

	always_comb begin
		illegal = 1'b0;
		alu_operator_o = ALU_ADD;
		op_a_sel_o = OP_A_REG_A;
		op_b_sel_o = OP_B_IMM;
		imm_b_sel_o = IMM_B_I;
		rf_we = 1'b0;
		rf_wd_sel_o = RF_WD_EX;
		data_req = 1'b0;
		data_we = 1'b0;
		data_type_o = DATA_WORD;
		branch = 1'b0;
		jump = 1'b0;

		unique case (opcode)
			OPCODE_JAL, OPCODE_JALR: begin
				// link value pc + 4 goes through the alu.
				jump = 1'b1;
				rf_we = 1'b1;
				op_a_sel_o = OP_A_CURRPC;
				imm_b_sel_o = IMM_B_INCR_PC;
				illegal = (opcode == OPCODE_JALR) && (funct3 != 3'b000);
			end
			OPCODE_BRANCH: begin
				branch = 1'b1;
				op_b_sel_o = OP_B_REG_B;
				imm_b_sel_o = IMM_B_B;
				unique case (funct3)
					3'b000: alu_operator_o = ALU_EQ;
					3'b001: alu_operator_o = ALU_NE;
					3'b100: alu_operator_o = ALU_LT;
					3'b101: alu_operator_o = ALU_GE;
					3'b110: alu_operator_o = ALU_LTU;
					3'b111: alu_operator_o = ALU_GEU;
					default: illegal = 1'b1;
				endcase
			end
			OPCODE_STORE: begin
				data_req = 1'b1;
				data_we = 1'b1;
				imm_b_sel_o = IMM_B_S;
				unique case (funct3)
					3'b000: data_type_o = DATA_BYTE;
					3'b001: data_type_o = DATA_HALF;
					3'b010: data_type_o = DATA_WORD;
					default: illegal = 1'b1;
				endcase
			end
			OPCODE_LOAD: begin
				data_req = 1'b1;
				rf_we = 1'b1;
				rf_wd_sel_o = RF_WD_LSU;
				unique case (funct3)
					3'b000, 3'b100: data_type_o = DATA_BYTE;
					3'b001, 3'b101: data_type_o = DATA_HALF;
					3'b010: data_type_o = DATA_WORD;
					default: illegal = 1'b1;
				endcase
			end
			OPCODE_LUI: begin
				op_a_sel_o = OP_A_IMM;
				imm_b_sel_o = IMM_B_U;
				rf_we = 1'b1;
			end
			OPCODE_AUIPC: begin
				op_a_sel_o = OP_A_CURRPC;
				imm_b_sel_o = IMM_B_U;
				rf_we = 1'b1;
			end
			OPCODE_OP_IMM: begin
				rf_we = 1'b1;
				unique case (funct3)
					3'b000: alu_operator_o = ALU_ADD;
					3'b010: alu_operator_o = ALU_SLT;
					3'b011: alu_operator_o = ALU_SLTU;
					3'b100: alu_operator_o = ALU_XOR;
					3'b110: alu_operator_o = ALU_OR;
					3'b111: alu_operator_o = ALU_AND;
					3'b001: begin
						alu_operator_o = ALU_SLL;
						illegal = (funct7 != 7'b0000000);
					end
					default: begin
						// 3'b101, shift right, funct7 picks the kind.
						if (funct7 == 7'b0000000) begin
							alu_operator_o = ALU_SRL;
						end else if (funct7 == 7'b0100000) begin
							alu_operator_o = ALU_SRA;
						end else begin
							illegal = 1'b1;
						end
					end
				endcase
			end
			OPCODE_OP: begin
				rf_we = 1'b1;
				op_b_sel_o = OP_B_REG_B;
				unique case ({funct7, funct3})
					10'b0000000_000: alu_operator_o = ALU_ADD;
					10'b0100000_000: alu_operator_o = ALU_SUB;
					10'b0000000_001: alu_operator_o = ALU_SLL;
					10'b0000000_010: alu_operator_o = ALU_SLT;
					10'b0000000_011: alu_operator_o = ALU_SLTU;
					10'b0000000_100: alu_operator_o = ALU_XOR;
					10'b0000000_101: alu_operator_o = ALU_SRL;
					10'b0100000_101: alu_operator_o = ALU_SRA;
					10'b0000000_110: alu_operator_o = ALU_OR;
					10'b0000000_111: alu_operator_o = ALU_AND;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
	end

	// an illegal word must not touch state or the bus.
	assign illegal_insn_o = illegal;
	assign rf_we_o = rf_we & ~illegal;
	assign data_req_o = data_req & ~illegal;
	assign data_we_o = data_we & ~illegal;
	assign branch_o = branch & ~illegal;
	assign jump_o = jump & ~illegal;

endmodule

`default_nettype wire

//--- source/id_pkg.sv
`default_nettype none

package id_pkg;

	// **************************************************
	// widths and constants
	// **************************************************

	localparam int unsigned XLEN = 32;
	localparam int unsigned REG_ADDR_W = 5;
	localparam int unsigned NUM_REGS = 2 ** REG_ADDR_W;

	// no compressed support, so the pc always moves by a word.
	localparam logic [XLEN-1:0] PC_INCR = 32'h4;
	localparam logic [XLEN-1:0] ADDR_INCR = 32'h4;

	// **************************************************
	// major opcodes
	// **************************************************

	localparam logic [6:0] OPCODE_LOAD = 7'h03;
	localparam logic [6:0] OPCODE_OP_IMM = 7'h13;
	localparam logic [6:0] OPCODE_AUIPC = 7'h17;
	localparam logic [6:0] OPCODE_STORE = 7'h23;
	localparam logic [6:0] OPCODE_OP = 7'h33;
	localparam logic [6:0] OPCODE_LUI = 7'h37;
	localparam logic [6:0] OPCODE_BRANCH = 7'h63;
	localparam logic [6:0] OPCODE_JALR = 7'h67;
	localparam logic [6:0] OPCODE_JAL = 7'h6f;

	// **************************************************
	// selector and operator encodings
	// **************************************************

	// gaps in the numbering belong to comparisons this core never issues.
	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_XOR = 5'd2,
		ALU_OR = 5'd3,
		ALU_AND = 5'd4,
		ALU_SRA = 5'd5,
		ALU_SRL = 5'd6,
		ALU_SLL = 5'd7,
		ALU_LT = 5'd8,
		ALU_LTU = 5'd9,
		ALU_GE = 5'd14,
		ALU_GEU = 5'd15,
		ALU_EQ = 5'd16,
		ALU_NE = 5'd17,
		ALU_SLT = 5'd18,
		ALU_SLTU = 5'd19
	} alu_op_e;

	typedef enum logic [1:0] {
		OP_A_REG_A = 2'd0,
		OP_A_FWD = 2'd1,
		OP_A_CURRPC = 2'd2,
		OP_A_IMM = 2'd3
	} op_a_sel_e;

	typedef enum logic {
		OP_B_REG_B = 1'b0,
		OP_B_IMM = 1'b1
	} op_b_sel_e;

	typedef enum logic [2:0] {
		IMM_B_I = 3'd0,
		IMM_B_S = 3'd1,
		IMM_B_B = 3'd2,
		IMM_B_U = 3'd3,
		IMM_B_J = 3'd4,
		IMM_B_INCR_PC = 3'd5,
		IMM_B_INCR_ADDR = 3'd6
	} imm_b_sel_e;

	typedef enum logic {
		RF_WD_LSU = 1'b0,
		RF_WD_EX = 1'b1
	} rf_wd_sel_e;

	typedef enum logic [1:0] {
		DATA_WORD = 2'b00,
		DATA_HALF = 2'b01,
		DATA_BYTE = 2'b10
	} data_type_e;

endpackage

`default_nettype wire
